/* verilog.f */
source/bp_pkg.sv
source/global_branch_history.sv
source/pattern_history_table.sv
source/branch_target_buffer.sv
source/branch_correction_buffer.sv
source/fetch_pc_unit.sv
source/global_prediction_top.sv
verification/tb_global_prediction.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert \
    --top-module tb_global_prediction \
    -f verilog.f -o sim_tb --Mdir obj_dir

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

/* verification/tb_global_prediction.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_global_prediction;

    import bp_pkg::*;

    // Matches the DUT defaults
    localparam int bcb_depth = 4;
    localparam logic [31:0] stress_base = 32'h0000_0100;

    logic        clk;
    logic        arst_n;
    logic        ex_branch;
    logic        pcsrc;
    logic [31:0] ex_pc;
    logic [31:0] branch_target;
    logic        ex_jump;
    logic        ex_hit;
    logic [31:0] pc;
    logic        wrong;
    logic        unknown_taken;
    logic        hit;

    // Stimulus table with one queue per column
    string       row_name [$];
    logic        row_eb [$];
    logic        row_ps [$];
    logic [31:0] row_pc [$];
    logic [31:0] row_tgt [$];
    logic        row_ej [$];
    logic        row_eh [$];
    logic        row_rnd [$];
    int          row_reps [$];

    // Reference model state
    logic [31:0] lcg_state;
    logic [31:0] m_pc;
    logic [3:0]  m_hist;
    logic [1:0]  m_pht [16];
    logic        m_valid [16];
    logic [25:0] m_tag [16];
    logic [31:0] m_tgt [16];
    // In-flight BTB hits with the oldest at index 0
    logic        q_dir [$];
    logic [31:0] q_alt [$];
    logic [31:0] q_pc [$];
    logic [31:0] q_tgt [$];

    // Event counts for the directed scenarios
    int n_pred;
    int n_wrong;
    int n_flush;
    int n_unk;

    global_prediction_top uut (
        .clk(clk), .arst_n(arst_n),
        .ex_branch(ex_branch), .pcsrc(pcsrc), .ex_pc(ex_pc),
        .branch_target(branch_target), .ex_jump(ex_jump), .ex_hit(ex_hit),
        .pc(pc), .wrong(wrong), .unknown_taken(unknown_taken), .hit(hit)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic add_row(input string name, input logic eb, input logic ps,
                           input logic [31:0] epc, input logic [31:0] tgt, input logic ej,
                           input logic eh, input logic rnd, input int reps);
        row_name.push_back(name);
        row_eb.push_back(eb);
        row_ps.push_back(ps);
        row_pc.push_back(epc);
        row_tgt.push_back(tgt);
        row_ej.push_back(ej);
        row_eh.push_back(eh);
        row_rnd.push_back(rnd);
        row_reps.push_back(reps);
    endtask

    task automatic value_error(input string name, input string sig,
                               input logic [31:0] exp, input logic [31:0] act);
        $display("[ERROR] %s: %s expected %h actual %h", name, sig, exp, act);
        $display("TEST FAIL");
        $fatal(1, "value mismatch");
    endtask

    task automatic missing_event(input string what);
        $display("Scenario never happened during the run: %s", what);
        $display("TEST FAIL");
        $fatal(1, "coverage hole");
    endtask

    // Random execute-stage activity around a small set of branch PCs
    task automatic pick_random(output logic eb, output logic ps, output logic [31:0] epc,
                               output logic [31:0] tgt, output logic ej, output logic eh);
        logic [31:0] r;
        r = lcg_next();
        eb = 1'b0;
        ps = 1'b0;
        ej = 1'b0;
        eh = 1'b0;
        epc = '0;
        tgt = '0;
        if (q_dir.size() > 0 && r[17:16] < 2'd2) begin
            // Resolve the oldest hit
            // PC and target come from the queue later
            eb = 1'b1;
            eh = 1'b1;
            ps = r[20];
        end else if (r[19:17] == 3'd5) begin
            eb = 1'b1;
            ps = r[20];
            epc = stress_base + {27'd0, r[23:21], 2'b00};
            tgt = stress_base + {27'd0, r[26:24], 2'b00};
        end else if (r[22:18] == 5'd9) begin
            // Jump from outside the set into BTB slot 0
            ej = 1'b1;
            epc = 32'h0000_0200;
            tgt = stress_base + {27'd0, r[27:25], 2'b00};
        end
    endtask

    // Expected outputs for this cycle and model state for the next one
    task automatic step_model(input string name, input logic eb, input logic ps,
                              input logic [31:0] epc, input logic [31:0] tgt,
                              input logic ej, input logic eh);
        logic [3:0]  idx;
        logic [3:0]  widx;
        logic        e_hit;
        logic        e_taken;
        logic        e_unk;
        logic        e_wrong;
        logic        pop;
        logic        redir;
        logic [31:0] e_ptgt;
        logic [31:0] nxt;
        idx = m_pc[5:2];
        e_hit = m_valid[idx] && (m_tag[idx] == m_pc[31:6]);
        e_ptgt = m_tgt[idx];
        // Weak taken or strong taken
        e_taken = (m_pht[m_hist] >= 2'd2);
        e_unk = eb && ps && !eh;
        pop = eb && eh;
        e_wrong = pop && (q_dir.size() > 0) && (ps != q_dir[0]);
        redir = ej || e_unk || e_wrong;
        if (ej || e_unk) begin
            nxt = tgt;
        end else if (e_wrong) begin
            nxt = q_alt[0];
        end else if (e_hit && e_taken) begin
            nxt = e_ptgt;
        end else begin
            nxt = m_pc + inst_step;
        end
        assert (pc === m_pc) else value_error(name, "pc", m_pc, pc);
        assert (hit === e_hit) else value_error(name, "hit", {31'd0, e_hit}, {31'd0, hit});
        assert (wrong === e_wrong)
            else value_error(name, "wrong", {31'd0, e_wrong}, {31'd0, wrong});
        assert (unknown_taken === e_unk)
            else value_error(name, "unknown_taken", {31'd0, e_unk}, {31'd0, unknown_taken});
        if (!redir && e_hit && e_taken) begin
            n_pred++;
        end
        if (e_wrong) begin
            n_wrong++;
        end
        if (e_wrong && q_dir.size() > 1) begin
            n_flush++;
        end
        if (e_unk) begin
            n_unk++;
        end
        // A redirect drops every in-flight entry
        if (redir) begin
            q_dir.delete();
            q_alt.delete();
            q_pc.delete();
            q_tgt.delete();
        end else begin
            if (pop) begin
                void'(q_dir.pop_front());
                void'(q_alt.pop_front());
                void'(q_pc.pop_front());
                void'(q_tgt.pop_front());
            end
            if (e_hit) begin
                q_dir.push_back(e_taken);
                q_alt.push_back(e_taken ? (m_pc + inst_step) : e_ptgt);
                q_pc.push_back(m_pc);
                q_tgt.push_back(e_ptgt);
            end
        end
        // Counter trains on pre-shift history
        if (eb) begin
            if (ps && m_pht[m_hist] != 2'd3) begin
                m_pht[m_hist] = m_pht[m_hist] + 2'd1;
            end else if (!ps && m_pht[m_hist] != 2'd0) begin
                m_pht[m_hist] = m_pht[m_hist] - 2'd1;
            end
            m_hist = {m_hist[2:0], ps};
        end
        if ((eb && ps) || ej) begin
            widx = epc[5:2];
            m_valid[widx] = 1'b1;
            m_tag[widx] = epc[31:6];
            m_tgt[widx] = tgt;
        end
        m_pc = nxt;
    endtask

    initial begin
        logic        eb;
        logic        ps;
        logic        ej;
        logic        eh;
        logic [31:0] epc;
        logic [31:0] tgt;
        int          waited;
        clk = 1'b0;
        arst_n = 1'b0;
        ex_branch = 1'b0;
        pcsrc = 1'b0;
        ex_pc = '0;
        branch_target = '0;
        ex_jump = 1'b0;
        ex_hit = 1'b0;
        lcg_state = 32'd39;
        n_pred = 0;
        n_wrong = 0;
        n_flush = 0;
        n_unk = 0;
        m_pc = reset_pc;
        m_hist = '0;
        for (int i = 0; i < 16; i++) begin
            // Weak not-taken
            m_pht[i] = 2'd1;
            m_valid[i] = 1'b0;
            m_tag[i] = '0;
            m_tgt[i] = '0;
        end

        add_row("reset_fall", 0, 0, 32'h0, 32'h0, 0, 0, 0, 4);
        add_row("unknown_taken", 1, 1, 32'h40, 32'h80, 0, 0, 0, 1);
        add_row("fall_after_unk", 0, 0, 32'h0, 32'h0, 0, 0, 0, 2);
        add_row("jump_redirect", 0, 0, 32'h48, 32'h40, 1, 0, 0, 1);
        add_row("btb_hit_nt", 0, 0, 32'h0, 32'h0, 0, 0, 0, 1);
        add_row("mispredict", 1, 1, 32'h0, 32'h0, 0, 1, 0, 1);
        add_row("train_taken", 1, 1, 32'h40, 32'h80, 0, 0, 0, 4);
        // Branch at 0x80 takes BTB slot 0 from 0x40
        // The loop back to 0x40 closes through the jump at 0x48
        add_row("install_back", 1, 1, 32'h80, 32'h40, 0, 0, 0, 1);
        // Two trips round the loop queue two taken predictions
        add_row("loop_fill", 0, 0, 32'h0, 32'h0, 0, 0, 0, 6);
        add_row("flush_younger", 1, 0, 32'h0, 32'h0, 0, 1, 0, 1);
        add_row("after_recover", 0, 0, 32'h0, 32'h0, 0, 0, 0, 2);
        for (int i = 0; i < 4; i++) begin
            add_row("alt_taken", 1, 1, 32'h50, 32'h90, 0, 0, 0, 1);
            add_row("alt_not", 1, 0, 32'h50, 32'h90, 0, 0, 0, 1);
        end
        add_row("jump_alt", 0, 0, 32'h4c, 32'h50, 1, 0, 0, 1);
        add_row("alt_fetch", 0, 0, 32'h0, 32'h0, 0, 0, 0, 3);
        add_row("alt_resolve", 1, 1, 32'h0, 32'h0, 0, 1, 0, 2);
        // Same branch under the other history pattern predicts not taken
        add_row("jump_alt_nt", 0, 0, 32'h4c, 32'h50, 1, 0, 0, 1);
        add_row("alt_fetch_nt", 0, 0, 32'h0, 32'h0, 0, 0, 0, 2);
        add_row("stress", 0, 0, 32'h0, 32'h0, 0, 0, 1, 300);
        add_row("drain", 0, 0, 32'h0, 32'h0, 0, 0, 0, 2);

        // PC must show the reset value while reset is held
        waited = 0;
        while (pc !== reset_pc || wrong !== 1'b0) begin
            if (waited == 10) begin
                $display("DUT never reached the reset PC while reset was held");
                $display("TEST FAIL");
                $fatal(1, "reset timeout");
            end
            @(negedge clk);
            waited++;
        end
        for (int c = 0; c < 10; c++) begin
            @(posedge clk);
        end

        for (int r = 0; r < row_name.size(); r++) begin
            for (int k = 0; k < row_reps[r]; k++) begin
                eb = row_eb[r];
                ps = row_ps[r];
                epc = row_pc[r];
                tgt = row_tgt[r];
                ej = row_ej[r];
                eh = row_eh[r];
                if (row_rnd[r]) begin
                    pick_random(eb, ps, epc, tgt, ej, eh);
                end
                // A resolving hit is the oldest queued fetch
                if (eh) begin
                    if (q_dir.size() == 0) begin
                        eb = 1'b0;
                        ps = 1'b0;
                        eh = 1'b0;
                    end else begin
                        epc = q_pc[0];
                        tgt = q_tgt[0];
                    end
                end
                // Resolve the oldest correctly when a hit would overflow the full queue
                if (m_valid[m_pc[5:2]] && m_tag[m_pc[5:2]] == m_pc[31:6]
                    && q_dir.size() == bcb_depth && !ej && !(eb && (eh || ps))) begin
                    eb = 1'b1;
                    eh = 1'b1;
                    ps = q_dir[0];
                    epc = q_pc[0];
                    tgt = q_tgt[0];
                end
                arst_n <= 1'b1;
                ex_branch <= eb;
                pcsrc <= ps;
                ex_pc <= epc;
                branch_target <= tgt;
                ex_jump <= ej;
                ex_hit <= eh;
                @(negedge clk);
                step_model(row_name[r], eb, ps, epc, tgt, ej, eh);
                @(posedge clk);
            end
        end

        assert (n_pred > 0) else missing_event("predicted taken redirect");
        assert (n_wrong > 0) else missing_event("misprediction");
        assert (n_flush > 0) else missing_event("misprediction with younger entries queued");
        assert (n_unk > 0) else missing_event("taken branch missing in the BTB");
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* source/global_prediction_top.sv */
`timescale 1ns/1ns
`default_nettype none

module global_prediction_top #(
    parameter int hist_bits      = 4,
    parameter int btb_index_bits = 4,
    parameter int bcb_depth      = 4
) (
    input  wire                       clk,
    input  wire                       arst_n,
    input  wire                       ex_branch,
    input  wire                       pcsrc,
    input  wire [bp_pkg::addr_w-1:0]  ex_pc,
    input  wire [bp_pkg::addr_w-1:0]  branch_target,
    input  wire                       ex_jump,
    input  wire                       ex_hit,
    output logic [bp_pkg::addr_w-1:0] pc,
    output logic                      wrong,
    output logic                      unknown_taken,
    output logic                      hit
);

    import bp_pkg::*;

    // Predictor internals
    logic [hist_bits-1:0] history;
    logic                 taken;
    logic [addr_w-1:0]    pred_target;
    logic [addr_w-1:0]    recovery_pc;

    // Global outcome history
    global_branch_history #(.hist_bits(hist_bits)) u_gbh (
        .clk(clk), .arst_n(arst_n),
        .ex_branch(ex_branch), .pcsrc(pcsrc),
        .history(history)
    );

    // Direction counters indexed by history
    pattern_history_table #(.hist_bits(hist_bits)) u_pht (
        .clk(clk), .arst_n(arst_n),
        .ex_branch(ex_branch), .ex_jump(ex_jump), .pcsrc(pcsrc),
        .history(history), .taken(taken)
    );

    // Target lookup and install
    branch_target_buffer #(.btb_index_bits(btb_index_bits)) u_btb (
        .clk(clk), .arst_n(arst_n), .pc(pc),
        .ex_branch(ex_branch), .ex_jump(ex_jump), .pcsrc(pcsrc),
        .ex_pc(ex_pc), .branch_target(branch_target),
        .hit(hit), .pred_target(pred_target)
    );

    // In-flight predictions and misprediction detect
    branch_correction_buffer #(.bcb_depth(bcb_depth)) u_bcb (
        .clk(clk), .arst_n(arst_n), .pc(pc),
        .hit(hit), .taken(taken), .pred_target(pred_target),
        .ex_branch(ex_branch), .ex_hit(ex_hit), .pcsrc(pcsrc),
        .ex_jump(ex_jump), .unknown_taken(unknown_taken),
        .wrong(wrong), .recovery_pc(recovery_pc)
    );

    // Next PC select and fetch PC register
    fetch_pc_unit u_fpc (
        .clk(clk), .arst_n(arst_n),
        .ex_branch(ex_branch), .ex_hit(ex_hit), .pcsrc(pcsrc),
        .ex_jump(ex_jump), .branch_target(branch_target),
        .wrong(wrong), .recovery_pc(recovery_pc),
        .hit(hit), .taken(taken), .pred_target(pred_target),
        .pc(pc), .unknown_taken(unknown_taken)
    );

endmodule

`default_nettype wire

/* source/fetch_pc_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_pc_unit (
    input  wire                       clk,
    input  wire                       arst_n,
    input  wire                       ex_branch,
    input  wire                       ex_hit,
    input  wire                       pcsrc,
    input  wire                       ex_jump,
    input  wire [bp_pkg::addr_w-1:0]  branch_target,
    input  wire                       wrong,
    input  wire [bp_pkg::addr_w-1:0]  recovery_pc,
    input  wire                       hit,
    input  wire                       taken,
    input  wire [bp_pkg::addr_w-1:0]  pred_target,
    output logic [bp_pkg::addr_w-1:0] pc,
    output logic                      unknown_taken
);

    import bp_pkg::*;

    logic [addr_w-1:0] pc_q;
    logic [addr_w-1:0] next_pc;
    logic              resolve_redirect;

    // Taken branch that was never seen by the BTB at fetch
    assign unknown_taken = ex_branch && pcsrc && !ex_hit;

    // Execute stage overrides everything else
    assign resolve_redirect = ex_jump || unknown_taken;

    // Four-level next PC priority
    always_comb begin
        if (resolve_redirect) begin
            next_pc = branch_target;
        end else if (wrong) begin
            // Back onto the path that was not predicted
            next_pc = recovery_pc;
        end else if (hit && taken) begin
            next_pc = pred_target;
        end else begin
            next_pc = pc_q + inst_step;
        end
    end

    // Fetch PC register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q <= reset_pc;
        end else begin
            pc_q <= next_pc;
        end
    end

    assign pc = pc_q;

    // Targets and recovery addresses are all instruction aligned
    assert property (@(posedge clk) disable iff (!arst_n)
        pc_q[byte_off_bits-1:0] == '0);

endmodule

`default_nettype wire

/* source/branch_correction_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module branch_correction_buffer #(
    parameter int bcb_depth = 4
) (
    input  wire                       clk,
    input  wire                       arst_n,
    input  wire [bp_pkg::addr_w-1:0]  pc,
    input  wire                       hit,
    input  wire                       taken,
    input  wire [bp_pkg::addr_w-1:0]  pred_target,
    input  wire                       ex_branch,
    input  wire                       ex_hit,
    input  wire                       pcsrc,
    input  wire                       ex_jump,
    input  wire                       unknown_taken,
    output logic                      wrong,
    output logic [bp_pkg::addr_w-1:0] recovery_pc
);

    import bp_pkg::*;

    localparam int ptr_w = (bcb_depth > 1) ? $clog2(bcb_depth) : 1;
    localparam int cnt_w = $clog2(bcb_depth + 1);

    // Queue payload of predicted direction and path not followed
    logic              dir_q [bcb_depth];
    logic [addr_w-1:0] alt_q [bcb_depth];

    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;

    logic push;
    logic pop;
    logic redirect;

    // Pointer advance with wrap for any depth
    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        if (p == ptr_w'(bcb_depth - 1)) begin
            return '0;
        end
        return p + ptr_w'(1);
    endfunction

    // Oldest in-flight BTB hit resolves
    assign pop = ex_branch && ex_hit;

    // Resolution disagrees with the recorded direction
    assign wrong       = pop && (count != '0) && (pcsrc != dir_q[rd_ptr]);
    assign recovery_pc = alt_q[rd_ptr];

    // Any front-end redirect
    // Younger entries are wrong-path
    assign redirect = ex_jump || unknown_taken || wrong;

    // Record only predictions that actually reach the pipe
    assign push = hit && !redirect;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (redirect) begin
            // Flush
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + cnt_w'(push) - cnt_w'(pop);
        end
    end

    // Alternate is fall-through when predicted taken, else the stored target
    always_ff @(posedge clk) begin
        if (push) begin
            dir_q[wr_ptr] <= taken;
            alt_q[wr_ptr] <= taken ? (pc + inst_step) : pred_target;
        end
    end

    // Pipeline keeps at most bcb_depth BTB hits in flight
    assert property (@(posedge clk) disable iff (!arst_n)
        (push && !pop) |-> (count != cnt_w'(bcb_depth)));

    // Every resolving BTB hit must have been recorded at fetch
    assert property (@(posedge clk) disable iff (!arst_n)
        pop |-> (count != '0));

endmodule

`default_nettype wire

/* source/branch_target_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module branch_target_buffer #(
    parameter int btb_index_bits = 4
) (
    input  wire                       clk,
    input  wire                       arst_n,
    input  wire [bp_pkg::addr_w-1:0]  pc,
    input  wire                       ex_branch,
    input  wire                       ex_jump,
    input  wire                       pcsrc,
    input  wire [bp_pkg::addr_w-1:0]  ex_pc,
    input  wire [bp_pkg::addr_w-1:0]  branch_target,
    output logic                      hit,
    output logic [bp_pkg::addr_w-1:0] pred_target
);

    import bp_pkg::*;

    localparam int btb_depth = 2 ** btb_index_bits;
    // Tag is everything above index and byte offset
    localparam int tag_bits  = addr_w - btb_index_bits - byte_off_bits;
    localparam int idx_lo    = byte_off_bits;
    localparam int idx_hi    = byte_off_bits + btb_index_bits - 1;
    localparam int tag_lo    = byte_off_bits + btb_index_bits;

    // Entry storage
    logic                btb_valid  [btb_depth];
    logic [tag_bits-1:0] btb_tag    [btb_depth];
    logic [addr_w-1:0]   btb_target [btb_depth];

    // Fetch side fields
    logic [btb_index_bits-1:0] rd_idx;
    logic [tag_bits-1:0]       rd_tag;

    // Resolve side fields
    logic [btb_index_bits-1:0] wr_idx;
    logic [tag_bits-1:0]       wr_tag;
    logic                      install;

    assign rd_idx = pc[idx_hi:idx_lo];
    assign rd_tag = pc[addr_w-1:tag_lo];
    assign wr_idx = ex_pc[idx_hi:idx_lo];
    assign wr_tag = ex_pc[addr_w-1:tag_lo];

    // Combinational lookup with the fetch PC
    assign hit         = btb_valid[rd_idx] && (btb_tag[rd_idx] == rd_tag);
    assign pred_target = btb_target[rd_idx];

    // Taken branches and all jumps get an entry
    assign install = (ex_branch && pcsrc) || ex_jump;

    // Valid bits only, cleared on reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < btb_depth; i++) begin
                btb_valid[i] <= 1'b0;
            end
        end else if (install) begin
            btb_valid[wr_idx] <= 1'b1;
        end
    end

    // Tag and target, overwrite whatever sits at this index
    always_ff @(posedge clk) begin
        if (install) begin
            btb_tag[wr_idx]    <= wr_tag;
            btb_target[wr_idx] <= branch_target;
        end
    end

    // A single instruction resolves per cycle
    assert property (@(posedge clk) disable iff (!arst_n)
        !(ex_branch && ex_jump));

endmodule

`default_nettype wire

/* source/pattern_history_table.sv */
`timescale 1ns/1ns
`default_nettype none

module pattern_history_table #(
    parameter int hist_bits = 4
) (
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire                 ex_branch,
    input  wire                 ex_jump,
    input  wire                 pcsrc,
    input  wire [hist_bits-1:0] history,
    output logic                taken
);

    import bp_pkg::*;

    // One counter per global history pattern
    localparam int pht_depth = 2 ** hist_bits;

    ctr_t ctr_mem [pht_depth];

    // One saturating step toward the resolved direction
    function automatic ctr_t ctr_step(input ctr_t cur, input logic up);
        ctr_t nxt;
        nxt = cur;
        if (up) begin
            if (cur != ctr_st) begin
                nxt = ctr_t'(cur + 2'd1);
            end
        end else begin
            if (cur != ctr_snt) begin
                nxt = ctr_t'(cur - 2'd1);
            end
        end
        return nxt;
    endfunction

    // Prediction straight from the counter MSB
    assign taken = ctr_mem[history][1];

    // Train with the history current at resolution, shift happens same edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < pht_depth; i++) begin
                ctr_mem[i] <= ctr_reset;
            end
        end else if (ex_branch) begin
            ctr_mem[history] <= ctr_step(ctr_mem[history], pcsrc);
        end
    end

    // Taken outcome only comes with a resolving branch or jump
    assert property (@(posedge clk) disable iff (!arst_n)
        pcsrc |-> (ex_branch || ex_jump));

endmodule

`default_nettype wire

/* source/global_branch_history.sv */
`timescale 1ns/1ns
`default_nettype none

module global_branch_history #(
    parameter int hist_bits = 4
) (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire                  ex_branch,
    input  wire                  pcsrc,
    output logic [hist_bits-1:0] history
);

    // Shift register of resolved conditional branch outcomes
    // Newest outcome enters at the LSB
    logic [hist_bits-1:0] hist_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hist_q <= '0;
        end else if (ex_branch) begin
            // Only conditional branches move the pattern
            hist_q <= {hist_q[hist_bits-2:0], pcsrc};
        end
    end

    // New outcome reaches the PHT one cycle later
    assign history = hist_q;

endmodule

`default_nettype wire

/* source/bp_pkg.sv */
`default_nettype none

package bp_pkg;

    // PC and branch target width
    localparam int addr_w = 32;

    // Byte offset within a 32-bit instruction word
    localparam int byte_off_bits = 2;

    // Fetch address out of reset
    localparam logic [addr_w-1:0] reset_pc = 32'h0000_0000;

    // Fall-through step to the next sequential instruction
    localparam logic [addr_w-1:0] inst_step = 32'd4;

    // 2-bit saturating direction counter, MSB gives the taken prediction
    typedef enum logic [1:0] {
        ctr_snt = 2'b00,
        ctr_wnt = 2'b01,
        ctr_wt  = 2'b10,
        ctr_st  = 2'b11
    } ctr_t;

    // Counters start just on the not-taken side
    localparam ctr_t ctr_reset = ctr_wnt;

endpackage

`default_nettype wire
